// ==== sources.f ====
src/core_cfg_pkg.sv
src/pred_types_pkg.sv
src/cfi_decode.sv
src/ras.sv
src/ras_ckpt_table.sv
src/ras_predict_unit.sv
tests/tb_ras_predict_unit.sv

// ==== src/cfi_decode.sv ====
// --------------------
// RESP stage jump classifier, fully combinational
// no compressed instructions; the link address is always pc + 4
// a mispredict in the same cycle suppresses the stack action
// --------------------

`timescale 1ns/100ps

module cfi_decode (
    input  logic                    CLK,
    input  logic                    nRST,

    // RESP stage
    input  logic                    resp_valid,
    input  pred_types_pkg::instr_t  resp_instr,
    input  pred_types_pkg::pc_t     resp_pc,

    // resolve
    input  logic                    resolve_mispredict,

    // to stack and out
    output pred_types_pkg::ras_op_t op,
    output logic                    pred_ret
);

    import core_cfg_pkg::*;
    import pred_types_pkg::*;

    // --------------------
    // instruction fields
    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;

    logic       act;
    logic       is_jal;
    logic       is_jalr;
    logic       rd_link;
    logic       rs1_link;

    assign opcode = resp_instr[6:0];
    assign rd     = resp_instr[11:7];
    assign rs1    = resp_instr[19:15];

    // RESP is dropped when a mispredict lands in the same cycle
    assign act = resp_valid & ~resolve_mispredict;

    assign is_jal  = act & (opcode == OPC_JAL);
    assign is_jalr = act & (opcode == OPC_JALR);

    // ra or t0 counts as a link register
    assign rd_link  = (rd == REG_RA) | (rd == REG_T0);
    assign rs1_link = (rs1 == REG_RA) | (rs1 == REG_T0);

    // --------------------
    // hint table
    always_comb begin
        op.push      = 1'b0;
        op.pop       = 1'b0;
        // return address of this jump
        op.link_addr = resp_pc + pc_t'(4);

        // call through jal
        if (is_jal) begin
            op.push = rd_link;
        end
        else if (is_jalr) begin
            // any linking rd is a call
            op.push = rd_link;
            // return, unless rd == rs1 both linking (plain call)
            // rd != rs1 both linking is the coroutine swap, pop then push
            op.pop  = rs1_link & (~rd_link | (rd != rs1));
        end
    end

    // a return consumes the top entry
    assign pred_ret = op.pop;

    // a valid RESP slot carries a known instruction
    ap_valid_instr_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        resp_valid |-> !$isunknown(resp_instr)
    );

endmodule

// ==== src/core_cfg_pkg.sv ====
// --------------------
// predictor sizing; pointer and tag widths must stay log2 of the counts
// link registers follow the RISC-V jump hint rules (ra and t0 only)
// --------------------

package core_cfg_pkg;

    // datapath width
    localparam int XLEN = 32;

    // return address stack
    localparam int RAS_ENTRIES      = 8;
    localparam int LOG_RAS_ENTRIES  = 3;
    // bit 0 of a target is always 0, so it is not stored
    localparam int RAS_TARGET_WIDTH = XLEN - 1;

    // in-flight tags for checkpointing
    localparam int TAG_COUNT     = 8;
    localparam int LOG_TAG_COUNT = 3;

    // --------------------
    // encodings
    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    // link registers x1 and x5
    localparam logic [4:0] REG_RA = 5'd1;
    localparam logic [4:0] REG_T0 = 5'd5;

endpackage

// ==== src/pred_types_pkg.sv ====
// --------------------
// shared vector types and the structs passed between predictor blocks
// widths come from the config package
// --------------------

package pred_types_pkg;

    import core_cfg_pkg::*;

    // --------------------
    // vector types

    // full byte address
    typedef logic [XLEN-1:0] pc_t;

    // raw 32-bit instruction word
    typedef logic [XLEN-1:0] instr_t;

    // halfword address held in a stack entry
    typedef logic [RAS_TARGET_WIDTH-1:0] ras_target_t;

    // stack pointer, wraps modulo the depth
    typedef logic [LOG_RAS_ENTRIES-1:0] ras_idx_t;

    // in-flight instruction id
    typedef logic [LOG_TAG_COUNT-1:0] tag_t;

    // --------------------
    // block interfaces

    // decoder to stack
    // push and pop together means replace the top entry
    typedef struct packed {
        logic push;
        logic pop;
        pc_t  link_addr;
    } ras_op_t;

    // checkpoint table to stack
    // valid for one cycle, index is the pointer to go back to
    typedef struct packed {
        logic     valid;
        ras_idx_t index;
    } ras_restore_t;

endpackage

// ==== src/ras.sv ====
// --------------------
// 8-entry circular return address stack
// pointer-only restore; entries overwritten since a checkpoint stay lost
// overflow silently wraps over the oldest entry
// --------------------

`timescale 1ns/100ps

module ras (
    input  logic                          CLK,
    input  logic                          nRST,

    // from decoder
    input  pred_types_pkg::ras_op_t       op,

    // from checkpoint table
    input  pred_types_pkg::ras_restore_t  restore,

    // predicted return target, current pointer
    output pred_types_pkg::pc_t           target,
    output pred_types_pkg::ras_idx_t      ras_index
);

    import core_cfg_pkg::*;
    import pred_types_pkg::*;

    // --------------------
    // storage
    ras_target_t ras_array [RAS_ENTRIES];
    ras_idx_t    sp;

    // next-state controls
    ras_idx_t    next_sp;
    ras_idx_t    wr_idx;
    logic        wr_en;
    ras_idx_t    sp_inc;
    ras_idx_t    sp_dec;

    // wrap modulo depth through the pointer width
    assign sp_inc = ras_idx_t'(sp + ras_idx_t'(1));
    assign sp_dec = ras_idx_t'(sp - ras_idx_t'(1));

    // --------------------
    // action select
    always_comb begin
        next_sp = sp;
        wr_en   = 1'b0;
        wr_idx  = sp;

        // restore beats any RESP action
        if (restore.valid) begin
            next_sp = restore.index;
        end
        // swap: replace top in place, pointer holds
        else if (op.push & op.pop) begin
            wr_en  = 1'b1;
            wr_idx = sp;
        end
        // call: write above top and advance
        else if (op.push) begin
            wr_en   = 1'b1;
            wr_idx  = sp_inc;
            next_sp = sp_inc;
        end
        // return: step back, entry left in place
        else if (op.pop) begin
            next_sp = sp_dec;
        end
    end

    // --------------------
    // state
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sp <= '0;
            for (int i = 0; i < RAS_ENTRIES; i++) begin
                ras_array[i] <= '0;
            end
        end
        else begin
            sp <= next_sp;
            // drop bit 0 of the halfword-aligned link
            if (wr_en) begin
                ras_array[wr_idx] <= op.link_addr[XLEN-1:1];
            end
        end
    end

    // top entry, same cycle
    assign target    = {ras_array[sp], 1'b0};
    assign ras_index = sp;

    // snapshot must have been written before it is read back
    ap_restore_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        restore.valid |-> !$isunknown(restore.index)
    );

endmodule

// ==== src/ras_ckpt_table.sv ====
// --------------------
// per-tag snapshot of the stack pointer seen by each RESP instruction
// a tag holds one snapshot; a new RESP on the same tag overwrites it
// --------------------

`timescale 1ns/100ps

module ras_ckpt_table (
    input  logic                          CLK,
    input  logic                          nRST,

    // RESP stage
    input  logic                          resp_valid,
    input  pred_types_pkg::tag_t          resp_tag,
    input  pred_types_pkg::ras_idx_t      ras_index,

    // resolve
    input  logic                          resolve_mispredict,
    input  pred_types_pkg::tag_t          resolve_tag,

    // to stack
    output pred_types_pkg::ras_restore_t  restore
);

    import core_cfg_pkg::*;
    import pred_types_pkg::*;

    // --------------------
    // snapshot storage
    ras_idx_t               snap_idx [TAG_COUNT];
    logic [TAG_COUNT-1:0]   snap_valid;

    logic                   ckpt_wr;

    // RESP dropped by a same-cycle mispredict leaves no snapshot
    assign ckpt_wr = resp_valid & ~resolve_mispredict;

    // pointer before this RESP's own action
    always_ff @(posedge CLK) begin
        if (ckpt_wr) begin
            snap_idx[resp_tag] <= ras_index;
        end
    end

    // valid bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            snap_valid <= '0;
        end
        else begin
            if (ckpt_wr) begin
                snap_valid[resp_tag] <= 1'b1;
            end
            // consumed by the restore
            if (resolve_mispredict) begin
                snap_valid[resolve_tag] <= 1'b0;
            end
        end
    end

    // --------------------
    // read back in the mispredict cycle
    always_comb begin
        restore.valid = resolve_mispredict & snap_valid[resolve_tag];
        restore.index = snap_idx[resolve_tag];
    end

    // resolve only names tags issued through RESP
    ap_mispredict_tag_valid: assert property (
        @(posedge CLK) disable iff (!nRST)
        resolve_mispredict |-> snap_valid[resolve_tag]
    );

endmodule

// ==== src/ras_predict_unit.sv ====
// --------------------
// return-address predictor top: decoder -> stack <-> checkpoint table
// no back-pressure; all inputs are taken every cycle
// --------------------

`timescale 1ns/100ps

module ras_predict_unit (
    input  logic                    CLK,
    input  logic                    nRST,

    // RESP stage
    input  logic                    resp_valid,
    input  pred_types_pkg::instr_t  resp_instr,
    input  pred_types_pkg::pc_t     resp_pc,
    input  pred_types_pkg::tag_t    resp_tag,

    // resolve
    input  logic                    resolve_mispredict,
    input  pred_types_pkg::tag_t    resolve_tag,

    // prediction
    output logic                    pred_ret,
    output pred_types_pkg::pc_t     pred_target
);

    import pred_types_pkg::*;

    // --------------------
    // block links
    ras_op_t        op;
    ras_restore_t   restore;
    ras_idx_t       ras_index;

    // classify and form link address
    cfi_decode u_cfi_decode (
        .CLK                (CLK),
        .nRST               (nRST),
        .resp_valid         (resp_valid),
        .resp_instr         (resp_instr),
        .resp_pc            (resp_pc),
        .resolve_mispredict (resolve_mispredict),
        .op                 (op),
        .pred_ret           (pred_ret)
    );

    // stack, top entry is the prediction
    ras u_ras (
        .CLK        (CLK),
        .nRST       (nRST),
        .op         (op),
        .restore    (restore),
        .target     (pred_target),
        .ras_index  (ras_index)
    );

    // pointer snapshots per tag
    ras_ckpt_table u_ras_ckpt_table (
        .CLK                (CLK),
        .nRST               (nRST),
        .resp_valid         (resp_valid),
        .resp_tag           (resp_tag),
        .ras_index          (ras_index),
        .resolve_mispredict (resolve_mispredict),
        .resolve_tag        (resolve_tag),
        .restore            (restore)
    );

endmodule

// ==== tests/tb_ras_predict_unit.sv ====
// --------------------
// directed tests for the return-address predictor, with a small model stack
// inputs change 1 ns after the rising edge, outputs are checked 1 ns later
// --------------------

`timescale 1ns/100ps

module tb_ras_predict_unit;

    import core_cfg_pkg::*;
    import pred_types_pkg::*;

    // reset plus all tests, rounded up
    localparam int TEST_CYCLES = 50;
    // run limit, a wide margin over the test length
    localparam int MAX_CYCLES  = 8 * TEST_CYCLES;

    logic   CLK;
    logic   nRST;
    logic   resp_valid;
    instr_t resp_instr;
    pc_t    resp_pc;
    tag_t   resp_tag;
    logic   resolve_mispredict;
    tag_t   resolve_tag;
    logic   pred_ret;
    pc_t    pred_target;

    // --------------------
    // model state
    pc_t                  m_stack [RAS_ENTRIES];
    ras_idx_t             m_sp;
    ras_idx_t             m_snap [TAG_COUNT];
    logic [TAG_COUNT-1:0] m_snap_v;

    integer seed = 64;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     test_start;

    ras_predict_unit DUT (
        .CLK                (CLK),
        .nRST               (nRST),
        .resp_valid         (resp_valid),
        .resp_instr         (resp_instr),
        .resp_pc            (resp_pc),
        .resp_tag           (resp_tag),
        .resolve_mispredict (resolve_mispredict),
        .resolve_tag        (resolve_tag),
        .pred_ret           (pred_ret),
        .pred_target        (pred_target)
    );

    // 4 ns period
    always #2 CLK = ~CLK;

    // hang guard
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped: timeout after %0d cycles", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // --------------------
    // compare tasks
    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // --------------------
    // encoders
    function automatic instr_t enc_jal(input logic [4:0] rd);
        return {20'h00000, rd, OPC_JAL};
    endfunction

    function automatic instr_t enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'h000, rs1, 3'b000, rd, OPC_JALR};
    endfunction

    // word-aligned random PC
    task automatic random_pc(output pc_t pc);
        pc = $random(seed);
        pc[1:0] = 2'b00;
    endtask

    // expected {push, pop} from the link-register hint table
    function automatic logic [1:0] expected_action(input instr_t ins);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic       rd_l;
        logic       rs1_l;
        rd    = ins[11:7];
        rs1   = ins[19:15];
        rd_l  = (rd == 5'd1) || (rd == 5'd5);
        rs1_l = (rs1 == 5'd1) || (rs1 == 5'd5);
        if (ins[6:0] == OPC_JAL) begin
            return {rd_l, 1'b0};
        end
        if (ins[6:0] != OPC_JALR) begin
            return 2'b00;
        end
        case ({rd_l, rs1_l})
            2'b01:   return 2'b01;
            2'b10:   return 2'b10;
            // both linking, same register is a plain call
            2'b11:   return (rd == rs1) ? 2'b10 : 2'b11;
            default: return 2'b00;
        endcase
    endfunction

    // --------------------
    // one cycle of stimulus, check, then model update
    task automatic drive_cycle(input logic valid, input instr_t ins, input pc_t pc,
                               input tag_t tag, input logic misp, input tag_t mtag);
        logic [1:0] act;
        pc_t        link;
        @(posedge CLK);
        #1;
        resp_valid         = valid;
        resp_instr         = ins;
        resp_pc            = pc;
        resp_tag           = tag;
        resolve_mispredict = misp;
        resolve_tag        = mtag;
        #1;
        act = (valid && !misp) ? expected_action(ins) : 2'b00;
        link = pc + 32'd4;
        link[0] = 1'b0;
        check_bit("pred_ret", pred_ret, act[0]);
        check_pc("pred_target", pred_target, m_stack[m_sp]);
        if (misp) begin
            // pointer only, RESP in this cycle is lost
            if (m_snap_v[mtag]) begin
                m_sp = m_snap[mtag];
            end
            m_snap_v[mtag] = 1'b0;
        end
        else if (valid) begin
            m_snap[tag]   = m_sp;
            m_snap_v[tag] = 1'b1;
            if (act == 2'b11) begin
                m_stack[m_sp] = link;
            end
            else if (act == 2'b10) begin
                m_sp = m_sp + 3'd1;
                m_stack[m_sp] = link;
            end
            else if (act == 2'b01) begin
                m_sp = m_sp - 3'd1;
            end
        end
    endtask

    task automatic resp(input instr_t ins, input pc_t pc, input tag_t tag);
        drive_cycle(1'b1, ins, pc, tag, 1'b0, '0);
    endtask

    task automatic idle();
        drive_cycle(1'b0, '0, '0, '0, 1'b0, '0);
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %s (%0d errors)", name,
                 (errors == test_start) ? "ok" : "bad", errors - test_start);
    endtask

    // --------------------
    // tests
    task automatic test_reset();
        test_start = errors;
        // addi x0, x0, 0
        resp(32'h00000013, 32'h00001000, 3'd0);
        idle();
        finish_test("reset");
    endtask

    task automatic test_call_return();
        pc_t pc;
        test_start = errors;
        repeat (3) begin
            random_pc(pc);
            resp(enc_jal(REG_RA), pc, 3'd0);
        end
        // returns come back in reverse order
        repeat (3) begin
            random_pc(pc);
            resp(enc_jalr(5'd0, REG_RA), pc, 3'd0);
        end
        idle();
        finish_test("call_return");
    endtask

    task automatic test_overflow();
        pc_t pc;
        test_start = errors;
        // ninth push wraps over the first
        repeat (9) begin
            random_pc(pc);
            resp(enc_jal(REG_RA), pc, 3'd1);
        end
        repeat (9) begin
            random_pc(pc);
            resp(enc_jalr(5'd0, REG_RA), pc, 3'd1);
        end
        idle();
        finish_test("overflow");
    endtask

    task automatic test_coroutine();
        test_start = errors;
        resp(enc_jal(REG_RA), 32'h00002000, 3'd2);
        // t0 <- ra swap, top replaced
        resp(enc_jalr(REG_T0, REG_RA), 32'h00003000, 3'd2);
        idle();
        // non-link jumps leave the stack alone
        resp(enc_jal(5'd0), 32'h00004000, 3'd2);
        resp(enc_jalr(5'd0, 5'd6), 32'h00005000, 3'd2);
        // rd == rs1 == ra is a call
        resp(enc_jalr(REG_RA, REG_RA), 32'h00006000, 3'd2);
        idle();
        finish_test("coroutine");
    endtask

    task automatic test_recovery();
        test_start = errors;
        // tag 3 records the pointer before its push
        resp(enc_jal(REG_RA), 32'h00007000, 3'd3);
        resp(enc_jal(REG_RA), 32'h00007100, 3'd4);
        resp(enc_jal(REG_T0), 32'h00007200, 3'd5);
        // same-cycle push is dropped
        drive_cycle(1'b1, enc_jal(REG_RA), 32'h00007300, 3'd6, 1'b1, 3'd3);
        idle();
        // same-cycle return is dropped too, no pred_ret
        drive_cycle(1'b1, enc_jalr(5'd0, REG_RA), 32'h00007380, 3'd6, 1'b1, 3'd5);
        idle();
        resp(enc_jalr(5'd0, REG_RA), 32'h00007400, 3'd7);
        idle();
        finish_test("recovery");
    endtask

    // --------------------
    initial begin
        CLK                = 1'b0;
        nRST               = 1'b0;
        resp_valid         = 1'b0;
        resp_instr         = '0;
        resp_pc            = '0;
        resp_tag           = '0;
        resolve_mispredict = 1'b0;
        resolve_tag        = '0;
        m_sp               = '0;
        m_snap_v           = '0;
        for (int i = 0; i < RAS_ENTRIES; i++) begin
            m_stack[i] = '0;
        end
        for (int i = 0; i < TAG_COUNT; i++) begin
            m_snap[i] = '0;
        end
        repeat (3) @(posedge CLK);
        #1;
        nRST = 1'b1;

        test_reset();
        test_call_return();
        test_overflow();
        test_coroutine();
        test_recovery();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end
        else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
